/* Bender.yml */
package:
  name: board_parser

sources:
  # design, package first
  - common/nono_pkg.sv
  - rtl/token_decoder.sv
  - option_builder/option_builder.sv
  - rtl/option_store.sv
  - rtl/board_parser_top.sv

  # testbench
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_board_parser.sv

/* common/nono_pkg.sv */
package nono_pkg;

    // flag field, bits 7:5 of the first byte of a message
    typedef enum logic [2:0] {
        end_board   = 3'b000,
        end_line    = 3'b001,
        or_commit   = 3'b010,
        and_assign  = 3'b101,
        start_line  = 3'b110,
        start_board = 3'b111
    } msg_flag_e;

    // widths fixed by the byte format
    localparam int VAR_IDX_BITS = 4;
    localparam int OPT_BITS     = 2 ** VAR_IDX_BITS; // one bit per variable
    localparam int DIM_BITS     = 5;
    localparam int LINE_BITS    = 5;
    localparam int CNT_BITS     = 7;  // up to 127 options on a line

    // second byte of a start_board message
    typedef struct packed {
        logic [1:0]          spare_hi;
        logic [DIM_BITS-1:0] dim;      // bits 5:1
        logic                spare_lo;
    } dim_payload_t;

    // second byte of an and_assign message
    typedef struct packed {
        logic [2:0]              spare;
        logic [VAR_IDX_BITS-1:0] var_idx; // bits 4:1
        logic                    value;   // bit 0
    } assign_payload_t;

    // same byte, two readings picked by the flag
    typedef union packed {
        dim_payload_t    dim;
        assign_payload_t asg;
    } payload_u;

    typedef struct packed {
        msg_flag_e flag;
        payload_u  payload;
    } token_t;

    // one committed option of a line
    typedef struct packed {
        logic [LINE_BITS-1:0] line;
        logic [OPT_BITS-1:0]  bits;
    } option_rec_t;

endpackage

/* option_builder/option_builder.sv */
module option_builder #(
    parameter int MAX_LINES = 22
) (
    input  logic                          clk,
    input  logic                          rst,
    input  nono_pkg::token_t              tok,
    input  logic                          tok_valid,
    output nono_pkg::option_rec_t         rec,
    output logic                          rec_valid,
    output logic                          line_open,
    output logic                          board_start,
    output logic                          board_done,
    output logic [nono_pkg::DIM_BITS-1:0] n,
    output logic [nono_pkg::DIM_BITS-1:0] m
);
    import nono_pkg::*;

    localparam logic [LINE_BITS-1:0] LAST_LINE = LINE_BITS'(MAX_LINES - 1);

    logic                 dim_sel;  // 0 takes n, 1 takes m
    logic [LINE_BITS-1:0] line_idx;
    logic [OPT_BITS-1:0]  cur_opt;  // option under construction

    always_ff @(posedge clk) begin
        if (rst) begin
            dim_sel     <= 1'b0;
            line_idx    <= '0;
            cur_opt     <= '0;
            n           <= '0;
            m           <= '0;
            rec_valid   <= 1'b0;
            line_open   <= 1'b0;
            board_start <= 1'b0;
            board_done  <= 1'b0;
        end else begin
            // strobes last one cycle
            rec_valid   <= 1'b0;
            line_open   <= 1'b0;
            board_start <= 1'b0;
            board_done  <= 1'b0;

            if (tok_valid) begin
                case (tok.flag)
                    start_board: begin
                        dim_sel <= ~dim_sel;
                        if (!dim_sel) begin
                            n           <= tok.payload.dim.dim;
                            line_idx    <= '0;
                            cur_opt     <= '0;
                            board_start <= 1'b1; // new board
                        end else begin
                            m <= tok.payload.dim.dim;
                        end
                    end
                    start_line: begin
                        line_open <= 1'b1;
                        cur_opt   <= '0;
                    end
                    and_assign: begin
                        cur_opt[tok.payload.asg.var_idx] <= tok.payload.asg.value;
                    end
                    or_commit: begin
                        rec_valid <= 1'b1;
                        cur_opt   <= '0;
                    end
                    end_line: begin
                        rec_valid <= 1'b1;
                        cur_opt   <= '0;
                        if (line_idx != LAST_LINE) begin
                            line_idx <= line_idx + 1'b1; // saturates on last line
                        end
                    end
                    end_board: begin
                        board_done <= 1'b1;
                    end
                    default: ; // unused codes
                endcase
            end
        end
    end

    // record payload, line index also rides along with line_open
    always_ff @(posedge clk) begin
        if (tok_valid) begin
            case (tok.flag)
                start_line: begin
                    rec.line <= line_idx;
                end
                or_commit, end_line: begin
                    rec.line <= line_idx;
                    rec.bits <= cur_opt;
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/board_parser_top.sv */
module board_parser_top #(
    parameter  int MAX_LINES   = 22,
    parameter  int STORE_DEPTH = 64,
    localparam int ADDR_BITS   = $clog2(STORE_DEPTH)
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [7:0]                                    byte_in,
    input  logic                                          byte_valid,
    output logic                                          board_done,
    output logic [nono_pkg::DIM_BITS-1:0]                 n,
    output logic [nono_pkg::DIM_BITS-1:0]                 m,
    output logic                                          opt_valid,
    output nono_pkg::option_rec_t                         opt_rec,
    output logic [MAX_LINES-1:0][nono_pkg::CNT_BITS-1:0]  options_per_line,
    input  logic [ADDR_BITS-1:0]                          rd_addr,
    output nono_pkg::option_rec_t                         rd_data,
    input  logic [nono_pkg::LINE_BITS-1:0]                rd_line,
    output logic [ADDR_BITS-1:0]                          line_base_addr
);
    import nono_pkg::*;

    token_t      tok;
    logic        tok_valid;
    option_rec_t rec;
    logic        rec_valid;
    logic        line_open;
    logic        board_start;

    token_decoder token_decoder_inst (
        .clk        (clk),
        .rst        (rst),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .tok        (tok),
        .tok_valid  (tok_valid)
    );

    option_builder #(
        .MAX_LINES (MAX_LINES)
    ) option_builder_inst (
        .clk         (clk),
        .rst         (rst),
        .tok         (tok),
        .tok_valid   (tok_valid),
        .rec         (rec),
        .rec_valid   (rec_valid),
        .line_open   (line_open),
        .board_start (board_start),
        .board_done  (board_done),
        .n           (n),
        .m           (m)
    );

    option_store #(
        .MAX_LINES   (MAX_LINES),
        .STORE_DEPTH (STORE_DEPTH)
    ) option_store_inst (
        .clk              (clk),
        .rst              (rst),
        .rec              (rec),
        .rec_valid        (rec_valid),
        .line_open        (line_open),
        .board_start      (board_start),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data),
        .rd_line          (rd_line),
        .line_base_addr   (line_base_addr),
        .options_per_line (options_per_line),
        .opt_valid        (opt_valid),
        .opt_rec          (opt_rec)
    );

endmodule

/* rtl/option_store.sv */
module option_store #(
    parameter  int MAX_LINES   = 22,
    parameter  int STORE_DEPTH = 64,
    localparam int ADDR_BITS   = $clog2(STORE_DEPTH)
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  nono_pkg::option_rec_t                         rec,
    input  logic                                          rec_valid,
    input  logic                                          line_open,
    input  logic                                          board_start,
    input  logic [ADDR_BITS-1:0]                          rd_addr,
    output nono_pkg::option_rec_t                         rd_data,
    input  logic [nono_pkg::LINE_BITS-1:0]                rd_line,
    output logic [ADDR_BITS-1:0]                          line_base_addr,
    output logic [MAX_LINES-1:0][nono_pkg::CNT_BITS-1:0]  options_per_line,
    output logic                                          opt_valid,
    output nono_pkg::option_rec_t                         opt_rec
);
    import nono_pkg::*;

    option_rec_t          mem [STORE_DEPTH];
    logic [ADDR_BITS-1:0] line_base [MAX_LINES]; // first entry of each line
    logic [ADDR_BITS:0]   wr_ptr;                // one extra bit for full
    logic                 full;
    logic                 wr_en;

    assign full  = (wr_ptr == (ADDR_BITS + 1)'(STORE_DEPTH));
    assign wr_en = rec_valid && !full; // drop once memory is full

    // committed-option stream mirrors the accepted write
    assign opt_valid = wr_en;
    assign opt_rec   = rec;

    assign line_base_addr = (rd_line < MAX_LINES) ? line_base[rd_line] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= '0;
            options_per_line <= '0;
        end else if (board_start) begin
            wr_ptr           <= '0;
            options_per_line <= '0;
        end else begin
            if (line_open) begin
                options_per_line[rec.line] <= '0;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (options_per_line[rec.line] != '1) begin
                    options_per_line[rec.line] <= options_per_line[rec.line] + 1'b1;
                end
            end
        end
    end

    // memory and start table
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= rec;
        end
        if (line_open) begin
            line_base[rec.line] <= wr_ptr[ADDR_BITS-1:0];
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/token_decoder.sv */
module token_decoder (
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       byte_in,
    input  logic             byte_valid,
    output nono_pkg::token_t tok,
    output logic             tok_valid
);
    import nono_pkg::*;

    logic       phase;    // high while waiting for the payload byte
    logic [2:0] flag_buf; // flag of the first byte

    // pair phase only moves on accepted bytes
    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= 1'b0;
            tok_valid <= 1'b0;
        end else begin
            tok_valid <= 1'b0;
            if (byte_valid) begin
                phase <= ~phase;
                if (phase) begin
                    tok_valid <= 1'b1;
                end
            end
        end
    end

    // flag buffer and token registers
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (!phase) begin
                flag_buf <= byte_in[7:5];
            end else begin
                tok.flag    <= msg_flag_e'(flag_buf);
                tok.payload <= byte_in; // decoded later by flag
            end
        end
    end

endmodule

/* tb.f */
+incdir+testbench
common/nono_pkg.sv
rtl/token_decoder.sv
option_builder/option_builder.sv
rtl/option_store.sv
rtl/board_parser_top.sv
testbench/tb_board_parser.sv

/* testbench/tb_board_parser_table.svh */
`ifndef TB_BOARD_PARSER_TABLE_SVH
`define TB_BOARD_PARSER_TABLE_SVH

// stimulus pairs, {first byte, second byte}; flag in bits 15:13
localparam int NUM_PAIRS  = 31;
localparam int NUM_REC    = 8;
localparam int NUM_BOARDS = 2;
localparam int CHK_LINES  = 4; // lines above this expect a zero count

logic [15:0] stim_pairs [NUM_PAIRS] = '{
    16'hE7CB, 16'hE008,                       // board 0, n=5 m=4, spare bits set
    16'hC000, 16'hA001, 16'hA005, 16'h4000,   // line 0: v0 v2, or
    16'hA007, 16'h2000,                       // v3, end_line
    16'hC000, 16'hA01F, 16'hA003, 16'hA002,   // line 1: v15, v1 set then cleared
    16'h2000,
    16'hC000, 16'h2000,                       // line 2 commits an empty option
    16'h0000,                                 // end_board
    16'hE006, 16'hE00E,                       // board 1, n=3 m=7
    16'hC000, 16'hA009, 16'h4000,             // line 0: v4, or
    16'hA00B, 16'hA00D, 16'h4000,             // v5 v6, or
    16'hA00F, 16'h2000,                       // v7, end_line
    16'hC000, 16'h60FF, 16'hA013, 16'h2000,   // line 1: unused flag, v9
    16'h0000
};

// committed options in stream order, {line, bits}
option_rec_t exp_rec [NUM_REC] = '{
    {5'd0, 16'h0005}, {5'd0, 16'h0008}, {5'd1, 16'h8000}, {5'd2, 16'h0000},
    {5'd0, 16'h0010}, {5'd0, 16'h0060}, {5'd0, 16'h0080}, {5'd1, 16'h0200}
};
int rec_board [NUM_REC] = '{0, 0, 0, 0, 1, 1, 1, 1};

logic [CNT_BITS-1:0] exp_cnt [NUM_BOARDS][CHK_LINES] = '{'{2, 1, 1, 0}, '{3, 1, 0, 0}};
int exp_n [NUM_BOARDS] = '{5, 3};
int exp_m [NUM_BOARDS] = '{4, 7};

`endif

/* testbench/tb_board_parser.sv */
module tb_board_parser;
    timeunit 1ns;
    timeprecision 1ps;
    import nono_pkg::*;

    localparam int MAX_LINES = 22;
    localparam int ADDR_BITS = 6; // default store depth of 64

    `include "tb_board_parser_table.svh"

    localparam int WATCHDOG_CYCLES = NUM_PAIRS * 2 * 5 + 200;

    logic                                clk;
    logic                                rst;
    logic [7:0]                          byte_in;
    logic                                byte_valid;
    logic                                board_done;
    logic [DIM_BITS-1:0]                 n;
    logic [DIM_BITS-1:0]                 m;
    logic                                opt_valid;
    option_rec_t                         opt_rec;
    logic [MAX_LINES-1:0][CNT_BITS-1:0]  options_per_line;
    logic [ADDR_BITS-1:0]                rd_addr;
    option_rec_t                         rd_data;
    logic [LINE_BITS-1:0]                rd_line;
    logic [ADDR_BITS-1:0]                line_base_addr;

    int val_errors   = 0;
    int other_errors = 0;
    int mon_idx      = 0; // next expected record on the stream
    int done_count   = 0;

    board_parser_top board_parser_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            val_errors++;
        end
    endtask

    // one byte held for one cycle after 0 to 3 idle cycles
    task automatic send_byte(input logic [7:0] b);
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        byte_in    = b;
        byte_valid = 1'b1;
        @(posedge clk); // accepted here
        #1;
        byte_valid = 1'b0;
        byte_in    = '0;
    endtask

    task automatic wait_board_done();
        @(negedge clk);
        while (!board_done) @(negedge clk);
    endtask

    task automatic check_board(input int b);
        logic [CNT_BITS-1:0] exp;
        check_value("n", n, exp_n[b]);
        check_value("m", m, exp_m[b]);
        for (int k = 0; k < MAX_LINES; k++) begin
            exp = (k < CHK_LINES) ? exp_cnt[b][k] : '0;
            check_value($sformatf("options_per_line[%0d]", k), options_per_line[k], exp);
        end
    endtask

    // lines sit back to back in the store in commit order
    task automatic read_back(input int b);
        int          base;
        int          j;
        option_rec_t prev;
        logic        have_prev;
        base      = 0;
        prev      = '0;
        have_prev = 1'b0;
        for (int k = 0; k < CHK_LINES; k++) begin
            if (exp_cnt[b][k] != 0) begin
                @(posedge clk);
                #1;
                rd_line = k;
                @(negedge clk);
                check_value($sformatf("line_base_addr[%0d]", k), line_base_addr, base);
                j = 0;
                for (int r = 0; r < NUM_REC; r++) begin
                    if (rec_board[r] == b && exp_rec[r].line == k) begin
                        @(posedge clk);
                        #1;
                        rd_addr = base + j;
                        @(negedge clk); // new address not clocked in yet
                        if (have_prev) begin
                            check_value($sformatf("rd_data before read edge %0d", base + j),
                                        rd_data, prev);
                        end
                        @(posedge clk); // registered read
                        @(negedge clk);
                        check_value($sformatf("rd_data[%0d]", base + j), rd_data, exp_rec[r]);
                        prev      = exp_rec[r];
                        have_prev = 1'b1;
                        j++;
                    end
                end
                base += j;
            end
        end
    endtask

    // committed option stream in order
    always @(negedge clk) begin
        if (!rst) begin
            if (board_done) done_count++;
            if (opt_valid) begin
                assert (mon_idx < NUM_REC) else begin
                    $display("committed option seen beyond the expected list");
                    other_errors++;
                end
                if (mon_idx < NUM_REC) begin
                    check_value($sformatf("opt_rec #%0d", mon_idx), opt_rec, exp_rec[mon_idx]);
                end
                mon_idx++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        other_errors++;
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("summary: %0d value errors, %0d other errors", val_errors, other_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int board;
        void'($urandom(7));
        rst        = 1'b1;
        byte_in    = '0;
        byte_valid = 1'b0;
        rd_addr    = '0;
        rd_line    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // state right after reset
        check_value("n", n, 0);
        check_value("m", m, 0);
        check_value("opt_valid", opt_valid, 0);
        check_value("board_done", board_done, 0);
        for (int k = 0; k < MAX_LINES; k++) begin
            check_value($sformatf("options_per_line[%0d]", k), options_per_line[k], 0);
        end

        board = 0;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            send_byte(stim_pairs[i][15:8]);
            send_byte(stim_pairs[i][7:0]);
            if (stim_pairs[i][15:13] == end_board) begin
                wait_board_done();
                check_board(board);
                read_back(board);
                board++;
            end
        end

        assert (mon_idx == NUM_REC) else begin
            $display("option stream gave %0d records where %0d were expected",
                     mon_idx, NUM_REC);
            other_errors++;
        end
        check_value("board_done pulse count", done_count, NUM_BOARDS);

        $display("summary: %0d value errors, %0d other errors", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
